/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_serv_exec_top
FILELIST  = serv_exec_top.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
PASS_TEXT = Done: no errors

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* serv_alu.sv */
`timescale 1ns/1ps

module serv_alu
   import serv_pkg::*;
   (
   input  logic    clk,
   input  logic    i_rst_n,
   input  logic    i_load,
   input  logic    i_en,
   input  logic    i_cnt0,
   input  logic    i_cnt_done,
   input  alu_op_e i_op,
   input  logic    i_rs1,
   input  logic    i_op_b,
   output word_t   o_rd
   );

   alu_op_e op_q;
   logic    carry_q;
   word_t   acc_q;
   word_t   rd_q;

   logic sub_op;
   logic cmp_op;
   logic op_b_inv;
   logic carry_in;
   logic sum;
   logic carry_out;
   logic lt;
   logic res_bit;

   // Operation is held for the whole serial pass
   always_ff @(posedge clk) begin
      if (i_load) begin
         op_q <= i_op;
      end
   end

   // Compares reuse the subtractor
   assign sub_op = (op_q == ALU_SUB) || (op_q == ALU_SLT) || (op_q == ALU_SLTU);
   assign cmp_op = (op_q == ALU_SLT) || (op_q == ALU_SLTU);

   // Subtract as a + ~b + 1, the +1 enters as carry on bit 0
   assign op_b_inv  = i_op_b ^ sub_op;
   assign carry_in  = i_cnt0 ? sub_op : carry_q;
   assign sum       = i_rs1 ^ op_b_inv ^ carry_in;
   assign carry_out = (i_rs1 & op_b_inv) | (carry_in & (i_rs1 ^ op_b_inv));

   // Valid on the last bit, where i_rs1 and i_op_b are the sign bits.
   // No carry out of a - b means a borrow, so a < b unsigned.
   always_comb begin
      if ((op_q == ALU_SLT) && (i_rs1 != i_op_b)) begin
         lt = i_rs1;
      end else begin
         lt = ~carry_out;
      end
   end

   always_comb begin
      case (op_q)
         ALU_ADD,
         ALU_SUB: res_bit = sum;
         ALU_XOR: res_bit = i_rs1 ^ i_op_b;
         ALU_OR:  res_bit = i_rs1 | i_op_b;
         ALU_AND: res_bit = i_rs1 & i_op_b;
         default: res_bit = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_en) begin
         carry_q <= carry_out;
         acc_q   <= {res_bit, acc_q[XLEN-1:1]};
      end
   end

   // Result word only changes when a pass completes
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         rd_q <= '0;
      end else if (i_en && i_cnt_done) begin
         if (cmp_op) begin
            rd_q <= {{(XLEN-1){1'b0}}, lt};
         end else begin
            rd_q <= {res_bit, acc_q[XLEN-1:1]};
         end
      end
   end

   assign o_rd = rd_q;

   a_cnt0_in_run : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      i_cnt0 |-> i_en);

endmodule

/* serv_bufreg.sv */
`timescale 1ns/1ps

module serv_bufreg
   import serv_pkg::*;
   (
   input  logic  clk,
   input  logic  i_load,
   input  logic  i_en,
   input  word_t i_rs1,
   output logic  o_q
   );

   word_t data_q;

   // Operand a, LSB first
   always_ff @(posedge clk) begin
      if (i_load) begin
         data_q <= i_rs1;
      end else if (i_en) begin
         data_q <= {1'b0, data_q[XLEN-1:1]};
      end
   end

   assign o_q = data_q[0];

endmodule

/* serv_bufreg2.sv */
`timescale 1ns/1ps

module serv_bufreg2
   import serv_pkg::*;
   (
   input  logic  clk,
   input  logic  i_load,
   input  logic  i_en,
   input  logic  i_use_imm,
   input  word_t i_rs2,
   input  imm_t  i_imm,
   output logic  o_op_b
   );

   word_t data_q;
   word_t imm_ext;
   word_t load_val;

   // I-type immediate, sign bit copied into the upper bits
   assign imm_ext = {{(XLEN-IMM_W){i_imm[IMM_W-1]}}, i_imm};

   assign load_val = i_use_imm ? imm_ext : i_rs2;

   always_ff @(posedge clk) begin
      if (i_load) begin
         data_q <= load_val;
      end else if (i_en) begin
         data_q <= {1'b0, data_q[XLEN-1:1]};
      end
   end

   assign o_op_b = data_q[0];

endmodule

/* serv_exec_top.f */
serv_pkg.sv
serv_state.sv
serv_bufreg.sv
serv_bufreg2.sv
serv_alu.sv
serv_exec_top.sv
tb_serv_exec_top.sv

/* serv_exec_top.sv */
`timescale 1ns/1ps

module serv_exec_top
   import serv_pkg::*;
   (
   input  logic    clk,
   input  logic    i_rst_n,
   input  logic    i_start,
   input  alu_op_e i_op,
   input  logic    i_use_imm,
   input  word_t   i_rs1,
   input  word_t   i_rs2,
   input  imm_t    i_imm,
   output logic    o_busy,
   output logic    o_done,
   output word_t   o_rd
   );

   logic load;
   logic cnt_en;
   logic cnt0;
   logic cnt_done;
   logic op_a;
   logic op_b;

   serv_state state
     (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_start    (i_start),
      // Timing strobes
      .o_load     (load),
      .o_cnt_en   (cnt_en),
      .o_cnt0     (cnt0),
      .o_cnt_done (cnt_done),
      // Status
      .o_busy     (o_busy),
      .o_done     (o_done));

   serv_bufreg bufreg
     (
      .clk    (clk),
      .i_load (load),
      .i_en   (cnt_en),
      .i_rs1  (i_rs1),
      .o_q    (op_a));

   serv_bufreg2 bufreg2
     (
      .clk       (clk),
      .i_load    (load),
      .i_en      (cnt_en),
      .i_use_imm (i_use_imm),
      .i_rs2     (i_rs2),
      .i_imm     (i_imm),
      .o_op_b    (op_b));

   serv_alu alu
     (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      // State
      .i_load     (load),
      .i_en       (cnt_en),
      .i_cnt0     (cnt0),
      .i_cnt_done (cnt_done),
      // Control
      .i_op       (i_op),
      // Data
      .i_rs1      (op_a),
      .i_op_b     (op_b),
      .o_rd       (o_rd));

endmodule

/* serv_pkg.sv */
package serv_pkg;

   // Operand and result width
   localparam int XLEN = 32;

   // Raw immediate field from an I-type instruction
   localparam int IMM_W = 12;

   // Bit counter runs 0 .. LAST_BIT, one operand bit per cycle
   localparam int LAST_BIT = XLEN - 1;

   typedef logic [XLEN-1:0] word_t;

   typedef logic [IMM_W-1:0] imm_t;

   typedef logic [$clog2(XLEN)-1:0] cnt_t;

   // ALU operations
   typedef enum logic [2:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,
      ALU_XOR  = 3'd2,
      ALU_OR   = 3'd3,
      ALU_AND  = 3'd4,
      ALU_SLT  = 3'd5,
      ALU_SLTU = 3'd6
   } alu_op_e;

   // Sequencer states
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_RUN  = 2'd1,
      ST_DONE = 2'd2
   } state_e;

endpackage

/* serv_state.sv */
`timescale 1ns/1ps

module serv_state
   import serv_pkg::*;
   (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_start,
   output logic o_load,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_cnt_done,
   output logic o_busy,
   output logic o_done
   );

   state_e state_q;
   state_e state_d;
   cnt_t   cnt_q;
   logic   last_bit;

   assign last_bit = (cnt_q == cnt_t'(LAST_BIT));

   // Next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (i_start) begin
               state_d = ST_RUN;
            end
         end
         ST_RUN: begin
            if (last_bit) begin
               state_d = ST_DONE;
            end
         end
         ST_DONE: begin
            state_d = ST_IDLE;
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= ST_IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         if (o_load) begin
            cnt_q <= '0;
         end else if (o_cnt_en) begin
            // Wraps back to zero after the last bit
            cnt_q <= cnt_q + cnt_t'(1);
         end
      end
   end

   // Start is only accepted while idle
   assign o_load     = i_start && (state_q == ST_IDLE);
   assign o_cnt_en   = (state_q == ST_RUN);
   assign o_cnt0     = o_cnt_en && (cnt_q == '0);
   assign o_cnt_done = o_cnt_en && last_bit;
   assign o_busy     = (state_q != ST_IDLE);
   assign o_done     = (state_q == ST_DONE);

   // Load is followed by the first bit cycle
   a_load_starts_run : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_load |=> (o_cnt0 && o_busy));

   // Last bit is followed by a single done cycle
   a_done_after_last_bit : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_cnt_done |=> (o_done && !o_cnt_en));

endmodule

/* tb_serv_exec_top.sv */
`timescale 1ns/1ps

module tb_serv_exec_top;
   import serv_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int DONE_LAT   = 33;
   localparam int N_ARITH    = 40;
   localparam int N_LOGIC    = 30;
   localparam int N_CMP      = 30;
   localparam int N_CORNER   = 7;
   localparam int N_IMM      = 20;
   localparam int TOTAL_OPS  = N_ARITH + N_LOGIC + N_CMP + 2 * N_CORNER + 3 * N_IMM + 4;
   localparam int WATCHDOG_NS = TOTAL_OPS * 40 * CLK_PERIOD + 200 * CLK_PERIOD;

   logic    clk;
   logic    i_rst_n;
   logic    i_start;
   alu_op_e i_op;
   logic    i_use_imm;
   word_t   i_rs1;
   word_t   i_rs2;
   imm_t    i_imm;
   logic    o_busy;
   logic    o_done;
   word_t   o_rd;

   word_t   last_rd;
   int      err_count;
   word_t   corner_a [0:N_CORNER-1];
   word_t   corner_b [0:N_CORNER-1];

   serv_exec_top serv_exec_top_i (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_start   (i_start),
      .i_op      (i_op),
      .i_use_imm (i_use_imm),
      .i_rs1     (i_rs1),
      .i_rs2     (i_rs2),
      .i_imm     (i_imm),
      .o_busy    (o_busy),
      .o_done    (o_done),
      .o_rd      (o_rd)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // Run limit scales with the number of operations
   initial begin
      #(WATCHDOG_NS);
      $display("Simulation timed out before all operations finished");
      $display("Done: errors found");
      $fatal(1, "watchdog expired");
   end

   // Two's complement value of the immediate, widened to a word
   function automatic word_t sign_extend_imm(input imm_t imm);
      return word_t'(int'($signed(imm)));
   endfunction

   // Reference model of the RISC-V integer ops
   function automatic word_t expected_result(input alu_op_e op, input word_t a, input word_t b);
      word_t r;
      case (op)
         ALU_ADD:  r = a + b;
         ALU_SUB:  r = a - b;
         ALU_XOR:  r = a ^ b;
         ALU_OR:   r = a | b;
         ALU_AND:  r = a & b;
         ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
         default:  r = '0;
      endcase
      return r;
   endfunction

   task automatic check_value(input string name, input word_t exp, input word_t act);
      if (exp !== act) begin
         err_count++;
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         $display("Done: errors found");
         $fatal(1, "mismatch in %s", name);
      end
   endtask

   // One operation from start pulse to done, with latency and hold checks
   task automatic run_op(input string name, input alu_op_e op, input word_t a,
                         input word_t b, input logic use_imm, input imm_t imm);
      word_t exp_b;
      word_t exp_rd;
      int    cycles;
      exp_b  = use_imm ? sign_extend_imm(imm) : b;
      exp_rd = expected_result(op, a, exp_b);
      @(negedge clk);
      i_start   = 1'b1;
      i_op      = op;
      i_rs1     = a;
      i_rs2     = b;
      i_use_imm = use_imm;
      i_imm     = imm;
      cycles    = 0;
      do begin
         @(negedge clk);
         i_start = 1'b0;
         cycles++;
         check_value({name, " busy"}, 32'd1, word_t'(o_busy));
         if (!o_done) begin
            check_value({name, " hold"}, last_rd, o_rd);
         end
         if (cycles > DONE_LAT + 10) begin
            $display("No done pulse seen for %s", name);
            $display("Done: errors found");
            $fatal(1, "done timeout");
         end
      end while (!o_done);
      check_value({name, " latency"}, word_t'(DONE_LAT), word_t'(cycles));
      check_value({name, " result"}, exp_rd, o_rd);
      last_rd = o_rd;
      @(negedge clk);
      check_value({name, " done pulse"}, 32'd0, word_t'(o_done));
      check_value({name, " idle"}, 32'd0, word_t'(o_busy));
   endtask

   // Starts during the run and during the done cycle must be dropped
   task automatic busy_restart_test();
      word_t a1;
      word_t b1;
      word_t exp_rd;
      word_t done_rd;
      int    done_count;
      a1         = 32'h7FFF_F0F0;
      b1         = 32'h0001_1111;
      exp_rd     = expected_result(ALU_ADD, a1, b1);
      done_count = 0;
      done_rd    = '0;
      @(negedge clk);
      i_start   = 1'b1;
      i_op      = ALU_ADD;
      i_rs1     = a1;
      i_rs2     = b1;
      i_use_imm = 1'b0;
      for (int k = 1; k <= 45; k++) begin
         @(negedge clk);
         i_start = (k == 5) || (k == 32) || (k == 33);
         if (k == 5) begin
            i_op  = ALU_XOR;
            i_rs1 = 32'hFFFF_FFFF;
            i_rs2 = 32'h0F0F_0F0F;
         end
         if (o_done) begin
            done_count++;
            done_rd = o_rd;
         end
      end
      check_value("busy restart done count", 32'd1, word_t'(done_count));
      check_value("busy restart result", exp_rd, done_rd);
      check_value("busy restart hold", exp_rd, o_rd);
      check_value("busy restart idle", 32'd0, word_t'(o_busy));
      last_rd = o_rd;
   endtask

   initial begin
      word_t a;
      word_t b;
      imm_t  imm;
      int    sel;
      void'($urandom(31));
      err_count = 0;
      last_rd   = '0;
      i_rst_n   = 1'b0;
      i_start   = 1'b0;
      i_op      = ALU_ADD;
      i_use_imm = 1'b0;
      i_rs1     = '0;
      i_rs2     = '0;
      i_imm     = '0;
      corner_a  = '{32'h1234_5678, 32'h8000_0000, 32'h0000_0000, 32'hFFFF_FFFF,
                    32'h0000_0000, 32'h8000_0000, 32'hFFFF_FFFF};
      corner_b  = '{32'h1234_5678, 32'h0000_0000, 32'h8000_0000, 32'h0000_0000,
                    32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'hFFFF_FFFF};

      repeat (2) @(negedge clk);
      i_rst_n = 1'b1;
      check_value("reset busy", 32'd0, word_t'(o_busy));
      check_value("reset done", 32'd0, word_t'(o_done));
      check_value("reset rd", 32'd0, o_rd);

      for (int i = 0; i < N_ARITH; i++) begin
         a = $urandom;
         b = $urandom;
         run_op($sformatf("arith %0d", i), (i % 2 == 0) ? ALU_ADD : ALU_SUB, a, b, 1'b0, '0);
      end

      for (int i = 0; i < N_LOGIC; i++) begin
         a   = $urandom;
         b   = $urandom;
         sel = $urandom % 3;
         case (sel)
            0:       run_op($sformatf("xor %0d", i), ALU_XOR, a, b, 1'b0, '0);
            1:       run_op($sformatf("or %0d", i), ALU_OR, a, b, 1'b0, '0);
            default: run_op($sformatf("and %0d", i), ALU_AND, a, b, 1'b0, '0);
         endcase
      end

      for (int i = 0; i < N_CMP; i++) begin
         a = $urandom;
         b = $urandom;
         run_op($sformatf("cmp %0d", i), (i % 2 == 0) ? ALU_SLT : ALU_SLTU, a, b, 1'b0, '0);
      end

      // Equal, most negative and all-ones operands
      for (int i = 0; i < N_CORNER; i++) begin
         run_op($sformatf("slt corner %0d", i), ALU_SLT, corner_a[i], corner_b[i], 1'b0, '0);
         run_op($sformatf("sltu corner %0d", i), ALU_SLTU, corner_a[i], corner_b[i],
                1'b0, '0);
      end

      // rs2 is random junk here and must be ignored
      for (int i = 0; i < N_IMM; i++) begin
         a   = $urandom;
         b   = $urandom;
         imm = imm_t'($urandom);
         run_op($sformatf("addi %0d", i), ALU_ADD, a, b, 1'b1, imm);
         run_op($sformatf("slti %0d", i), ALU_SLT, a, b, 1'b1, imm);
         run_op($sformatf("sltiu %0d", i), ALU_SLTU, a, b, 1'b1, imm);
      end

      busy_restart_test();

      if (err_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule
